/* hdl/noc_topology_pkg.sv */
`default_nettype none

package noc_topology_pkg;

  ////////////////////
  // Mesh geometry

  localparam int mesh_x = 3;
  localparam int mesh_y = 2;
  localparam int nodes  = mesh_x * mesh_y;
  localparam int node_w = $clog2(nodes);

  // Node number from column and row
  function automatic int node_num(input int x, input int y);
    return x + y * mesh_x;
  endfunction

  ////////////////////
  // Router ports

  localparam int ports  = 5;
  localparam int port_w = $clog2(ports);

  // Indices into the per-router wiring arrays
  localparam int port_local = 0;
  localparam int port_north = 1;
  localparam int port_east  = 2;
  localparam int port_south = 3;
  localparam int port_west  = 4;

  // One-hot direction where bit n selects port n
  typedef logic [ports-1:0] dir_t;

  localparam dir_t dir_local = dir_t'(1 << port_local);
  localparam dir_t dir_north = dir_t'(1 << port_north);
  localparam dir_t dir_east  = dir_t'(1 << port_east);
  localparam dir_t dir_south = dir_t'(1 << port_south);
  localparam dir_t dir_west  = dir_t'(1 << port_west);

  // Input buffer sizing
  localparam int buffer_depth = 4;
  localparam int buffer_ptr_w = $clog2(buffer_depth);

endpackage

`default_nettype wire

/* hdl/noc_flit_pkg.sv */
`default_nettype none

package noc_flit_pkg;

  localparam int flit_w = 32;

  ////////////////////
  // Header layout

  localparam int dest_w = noc_topology_pkg::node_w;
  localparam int src_w  = noc_topology_pkg::node_w;
  // Whatever is left after the two node fields
  localparam int tag_w  = flit_w - dest_w - src_w;

  typedef struct packed {
    logic [dest_w-1:0] dest;
    logic [src_w-1:0]  src;
    logic [tag_w-1:0]  tag;
  } header_t;

  ////////////////////
  // Flit word

  // Header view is only meaningful on the first flit of a packet
  typedef union packed {
    header_t           header;
    logic [flit_w-1:0] data;
  } flit_t;

endpackage

`default_nettype wire

/* hdl/noc_router_input.sv */
`default_nettype none

module noc_router_input #(
  parameter int node_x = 0,
  parameter int node_y = 0
) (
  input  logic                   clk,
  input  logic                   arst_n,
  input  noc_flit_pkg::flit_t    in_flit,
  input  logic                   in_last,
  input  logic                   in_valid,
  output logic                   in_ready,
  output noc_flit_pkg::flit_t    head_flit,
  output logic                   head_last,
  output noc_topology_pkg::dir_t request,
  input  logic                   pop
);

  import noc_topology_pkg::*;
  import noc_flit_pkg::*;

  flit_t                   flit_mem [buffer_depth];
  logic                    last_mem [buffer_depth];
  logic [buffer_ptr_w-1:0] wr_ptr;
  logic [buffer_ptr_w-1:0] rd_ptr;
  logic [buffer_ptr_w:0]   count;
  logic                    push;
  logic                    packet_active;
  dir_t                    route_q;
  dir_t                    route_d;
  int                      dest_x;
  int                      dest_y;

  ////////////////////
  // Flit buffer

  assign in_ready = int'(count) < buffer_depth;
  assign push     = in_valid && in_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (int'(wr_ptr) == buffer_depth - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (int'(rd_ptr) == buffer_depth - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      flit_mem[wr_ptr] <= in_flit;
      last_mem[wr_ptr] <= in_last;
    end
  end

  assign head_flit = flit_mem[rd_ptr];
  assign head_last = last_mem[rd_ptr];

  ////////////////////
  // Route decision

  // X first, then Y, then deliver locally
  always_comb begin
    dest_x = int'(head_flit.header.dest) % mesh_x;
    dest_y = int'(head_flit.header.dest) / mesh_x;
    if (dest_x > node_x) begin
      route_d = dir_east;
    end else if (dest_x < node_x) begin
      route_d = dir_west;
    end else if (dest_y > node_y) begin
      route_d = dir_north;
    end else if (dest_y < node_y) begin
      route_d = dir_south;
    end else begin
      route_d = dir_local;
    end
  end

  // Body flits reuse the direction latched from the header
  assign request = (count != '0) ? (packet_active ? route_q : route_d) : '0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      packet_active <= 1'b0;
      route_q       <= '0;
    end else if (pop) begin
      packet_active <= !head_last;
      route_q       <= request;
    end
  end

endmodule

`default_nettype wire

/* hdl/noc_router_output.sv */
`default_nettype none

module noc_router_output (
  input  logic                                                 clk,
  input  logic                                                 arst_n,
  input  noc_topology_pkg::dir_t                               request,
  input  noc_flit_pkg::flit_t [noc_topology_pkg::ports-1:0]    head_flit,
  input  logic [noc_topology_pkg::ports-1:0]                   head_last,
  output logic [noc_topology_pkg::ports-1:0]                   grant,
  output noc_flit_pkg::flit_t                                  out_flit,
  output logic                                                 out_last,
  output logic                                                 out_valid,
  input  logic                                                 out_ready
);

  import noc_topology_pkg::*;
  import noc_flit_pkg::*;

  logic [port_w-1:0] rr_ptr;
  logic [port_w-1:0] pick;
  logic              found;
  logic              locked;
  logic              take;
  int                idx;

  ////////////////////
  // Arbitration

  // First requester after the last granted input wins
  always_comb begin
    found = 1'b0;
    pick  = rr_ptr;
    idx   = 0;
    for (int k = 1; k <= ports; k++) begin
      idx = (int'(rr_ptr) + k) % ports;
      if (!found && request[idx]) begin
        found = 1'b1;
        pick  = port_w'(idx);
      end
    end
  end

  // Grant only while the locked input actually has a flit
  assign grant = locked ? (request & (dir_t'(1) << rr_ptr)) : '0;
  assign take  = (|grant) && (!out_valid || out_ready);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      locked <= 1'b0;
      // Start so that input 0 comes first
      rr_ptr <= port_w'(ports - 1);
    end else if (!locked) begin
      if (found) begin
        locked <= 1'b1;
        rr_ptr <= pick;
      end
    end else if (take && head_last[rr_ptr]) begin
      locked <= 1'b0;
    end
  end

  ////////////////////
  // Output stage

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (take) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // Held while downstream stalls
  always_ff @(posedge clk) begin
    if (take) begin
      out_flit <= head_flit[rr_ptr];
      out_last <= head_last[rr_ptr];
    end
  end

endmodule

`default_nettype wire

/* hdl/noc_router.sv */
`default_nettype none

module noc_router #(
  parameter int node_x = 0,
  parameter int node_y = 0
) (
  input  logic                                              clk,
  input  logic                                              arst_n,
  input  noc_flit_pkg::flit_t [noc_topology_pkg::ports-1:0] in_flit,
  input  logic [noc_topology_pkg::ports-1:0]                in_last,
  input  logic [noc_topology_pkg::ports-1:0]                in_valid,
  output logic [noc_topology_pkg::ports-1:0]                in_ready,
  output noc_flit_pkg::flit_t [noc_topology_pkg::ports-1:0] out_flit,
  output logic [noc_topology_pkg::ports-1:0]                out_last,
  output logic [noc_topology_pkg::ports-1:0]                out_valid,
  input  logic [noc_topology_pkg::ports-1:0]                out_ready
);

  import noc_topology_pkg::*;
  import noc_flit_pkg::*;

  // Indexed by input
  flit_t [ports-1:0] head_flit;
  logic [ports-1:0]  head_last;
  dir_t              request [ports];
  logic [ports-1:0]  pop;

  // Indexed by output
  dir_t              out_request [ports];
  logic [ports-1:0]  grant [ports];
  logic [ports-1:0]  accept;

  for (genvar p = 0; p < ports; p++) begin : g_port
    noc_router_input #(
      .node_x (node_x),
      .node_y (node_y)
    ) u_input (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_flit   (in_flit[p]),
      .in_last   (in_last[p]),
      .in_valid  (in_valid[p]),
      .in_ready  (in_ready[p]),
      .head_flit (head_flit[p]),
      .head_last (head_last[p]),
      .request   (request[p]),
      .pop       (pop[p])
    );

    noc_router_output u_output (
      .clk       (clk),
      .arst_n    (arst_n),
      .request   (out_request[p]),
      .head_flit (head_flit),
      .head_last (head_last),
      .grant     (grant[p]),
      .out_flit  (out_flit[p]),
      .out_last  (out_last[p]),
      .out_valid (out_valid[p]),
      .out_ready (out_ready[p])
    );

    // Output p sees bit p of every input's request
    for (genvar q = 0; q < ports; q++) begin : g_xbar
      assign out_request[p][q] = request[q][p];
    end

    // Same condition the output uses to load its stage
    assign accept[p] = !out_valid[p] || out_ready[p];
  end

  ////////////////////
  // Pop collection

  always_comb begin
    pop = '0;
    for (int o = 0; o < ports; o++) begin
      pop = pop | (grant[o] & {ports{accept[o]}});
    end
  end

endmodule

`default_nettype wire

/* hdl/noc_mesh_2d.sv */
`default_nettype none

module noc_mesh_2d (
  input  logic                                              clk,
  input  logic                                              arst_n,
  input  noc_flit_pkg::flit_t [noc_topology_pkg::nodes-1:0] in_flit,
  input  logic [noc_topology_pkg::nodes-1:0]                in_last,
  input  logic [noc_topology_pkg::nodes-1:0]                in_valid,
  output logic [noc_topology_pkg::nodes-1:0]                in_ready,
  output noc_flit_pkg::flit_t [noc_topology_pkg::nodes-1:0] out_flit,
  output logic [noc_topology_pkg::nodes-1:0]                out_last,
  output logic [noc_topology_pkg::nodes-1:0]                out_valid,
  input  logic [noc_topology_pkg::nodes-1:0]                out_ready
);

  import noc_topology_pkg::*;
  import noc_flit_pkg::*;

  // Per node, per port link wires
  flit_t [ports-1:0] node_in_flit   [nodes];
  logic [ports-1:0]  node_in_last   [nodes];
  logic [ports-1:0]  node_in_valid  [nodes];
  logic [ports-1:0]  node_in_ready  [nodes];
  flit_t [ports-1:0] node_out_flit  [nodes];
  logic [ports-1:0]  node_out_last  [nodes];
  logic [ports-1:0]  node_out_valid [nodes];
  logic [ports-1:0]  node_out_ready [nodes];

  for (genvar y = 0; y < mesh_y; y++) begin : g_row
    for (genvar x = 0; x < mesh_x; x++) begin : g_col

      localparam int node = node_num(x, y);

      noc_router #(
        .node_x (x),
        .node_y (y)
      ) u_router (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_flit   (node_in_flit[node]),
        .in_last   (node_in_last[node]),
        .in_valid  (node_in_valid[node]),
        .in_ready  (node_in_ready[node]),
        .out_flit  (node_out_flit[node]),
        .out_last  (node_out_last[node]),
        .out_valid (node_out_valid[node]),
        .out_ready (node_out_ready[node])
      );

      ////////////////////
      // Local port

      assign node_in_flit[node][port_local]   = in_flit[node];
      assign node_in_last[node][port_local]   = in_last[node];
      assign node_in_valid[node][port_local]  = in_valid[node];
      assign in_ready[node] = node_in_ready[node][port_local];

      assign out_flit[node]  = node_out_flit[node][port_local];
      assign out_last[node]  = node_out_last[node][port_local];
      assign out_valid[node] = node_out_valid[node][port_local];
      assign node_out_ready[node][port_local] = out_ready[node];

      ////////////////////
      // Neighbour links

      // Border ports are tied off so they never send or accept
      if (y < mesh_y - 1) begin : g_north
        assign node_in_flit[node][port_north]   = node_out_flit[node_num(x, y + 1)][port_south];
        assign node_in_last[node][port_north]   = node_out_last[node_num(x, y + 1)][port_south];
        assign node_in_valid[node][port_north]  = node_out_valid[node_num(x, y + 1)][port_south];
        assign node_out_ready[node][port_north] = node_in_ready[node_num(x, y + 1)][port_south];
      end else begin : g_north_edge
        assign node_in_flit[node][port_north]   = '0;
        assign node_in_last[node][port_north]   = 1'b0;
        assign node_in_valid[node][port_north]  = 1'b0;
        assign node_out_ready[node][port_north] = 1'b0;
      end

      if (y > 0) begin : g_south
        assign node_in_flit[node][port_south]   = node_out_flit[node_num(x, y - 1)][port_north];
        assign node_in_last[node][port_south]   = node_out_last[node_num(x, y - 1)][port_north];
        assign node_in_valid[node][port_south]  = node_out_valid[node_num(x, y - 1)][port_north];
        assign node_out_ready[node][port_south] = node_in_ready[node_num(x, y - 1)][port_north];
      end else begin : g_south_edge
        assign node_in_flit[node][port_south]   = '0;
        assign node_in_last[node][port_south]   = 1'b0;
        assign node_in_valid[node][port_south]  = 1'b0;
        assign node_out_ready[node][port_south] = 1'b0;
      end

      if (x < mesh_x - 1) begin : g_east
        assign node_in_flit[node][port_east]   = node_out_flit[node_num(x + 1, y)][port_west];
        assign node_in_last[node][port_east]   = node_out_last[node_num(x + 1, y)][port_west];
        assign node_in_valid[node][port_east]  = node_out_valid[node_num(x + 1, y)][port_west];
        assign node_out_ready[node][port_east] = node_in_ready[node_num(x + 1, y)][port_west];
      end else begin : g_east_edge
        assign node_in_flit[node][port_east]   = '0;
        assign node_in_last[node][port_east]   = 1'b0;
        assign node_in_valid[node][port_east]  = 1'b0;
        assign node_out_ready[node][port_east] = 1'b0;
      end

      if (x > 0) begin : g_west
        assign node_in_flit[node][port_west]   = node_out_flit[node_num(x - 1, y)][port_east];
        assign node_in_last[node][port_west]   = node_out_last[node_num(x - 1, y)][port_east];
        assign node_in_valid[node][port_west]  = node_out_valid[node_num(x - 1, y)][port_east];
        assign node_out_ready[node][port_west] = node_in_ready[node_num(x - 1, y)][port_east];
      end else begin : g_west_edge
        assign node_in_flit[node][port_west]   = '0;
        assign node_in_last[node][port_west]   = 1'b0;
        assign node_in_valid[node][port_west]  = 1'b0;
        assign node_out_ready[node][port_west] = 1'b0;
      end

    end
  end

endmodule

`default_nettype wire

/* verif/noc_mesh_tb.sv */
`default_nettype none

module noc_mesh_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import noc_topology_pkg::*;
  import noc_flit_pkg::*;

  typedef struct {
    int wave;
    int src;
    int dst;
    int body;
    bit bp;
  } packet_entry_t;

  localparam int num_entries = 11;
  localparam int cycle_limit = 200 * num_entries;

  ////////////////////
  // Packet table

  // Entries of one wave launch together and waves run one after another
  packet_entry_t pkt_table [num_entries] = '{
    '{0, 4, 4, 2, 1'b0},  // Local delivery
    '{1, 0, 5, 3, 1'b0},  // Corner to corner
    '{1, 5, 0, 1, 1'b0},
    '{1, 2, 3, 0, 1'b0},  // Header only
    '{2, 0, 2, 4, 1'b0},  // Two sources into node 2
    '{2, 5, 2, 4, 1'b0},
    '{2, 0, 2, 2, 1'b0},
    '{2, 5, 2, 3, 1'b0},
    '{3, 3, 1, 5, 1'b1},  // Node 1 stalls its output
    '{3, 4, 1, 3, 1'b1},
    '{3, 3, 1, 2, 1'b1}
  };

  logic                    clk;
  logic                    arst_n;
  flit_t [nodes-1:0]       in_flit;
  logic [nodes-1:0]        in_last;
  logic [nodes-1:0]        in_valid;
  logic [nodes-1:0]        in_ready;
  flit_t [nodes-1:0]       out_flit;
  logic [nodes-1:0]        out_last;
  logic [nodes-1:0]        out_valid;
  logic [nodes-1:0]        out_ready;

  // Each queued word is {last, flit}
  logic [flit_w:0]         tx_q [nodes][$];
  logic [flit_w:0]         exp_q [nodes*nodes][$];
  logic [nodes-1:0]        in_fire;
  int                      hold_cnt [nodes];
  logic                    in_packet [nodes];
  int                      cur_src [nodes];
  logic [31:0]             rng_state;
  int                      cycle_count;

  noc_mesh_2d UUT (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_flit   (in_flit),
    .in_last   (in_last),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_flit  (out_flit),
    .out_last  (out_last),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  always #50 clk = ~clk;

  ////////////////////
  // Helpers

  task automatic stop_on_failure();
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
    if (actual !== expected) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      stop_on_failure();
    end
  endtask

  // xorshift32
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  function automatic bit network_idle();
    for (int n = 0; n < nodes; n++) begin
      if (tx_q[n].size() != 0 || hold_cnt[n] != 0) begin
        return 1'b0;
      end
    end
    for (int q = 0; q < nodes * nodes; q++) begin
      if (exp_q[q].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // Header goes first and only the final flit carries last
  task automatic queue_packet(input packet_entry_t e);
    flit_t           flit;
    logic [flit_w:0] word;
    int              q;
    q = e.src * nodes + e.dst;
    flit = '0;
    flit.header.dest = dest_w'(e.dst);
    flit.header.src  = src_w'(e.src);
    flit.header.tag  = tag_w'(next_random());
    word = {e.body == 0, flit.data};
    tx_q[e.src].push_back(word);
    exp_q[q].push_back(word);
    for (int b = 0; b < e.body; b++) begin
      flit.data = next_random();
      word = {b == e.body - 1, flit.data};
      tx_q[e.src].push_back(word);
      exp_q[q].push_back(word);
    end
    if (e.bp) begin
      hold_cnt[e.dst] = 15 + int'(next_random() % 30);
    end
  endtask

  task automatic wait_idle();
    do begin
      @(posedge clk);
      #10;
    end while (!network_idle());
  endtask

  ////////////////////
  // Scoreboard

  // A body flit must belong to the packet whose header came last
  task automatic check_arrival(input int node, input flit_t flit, input logic last);
    logic [flit_w:0] exp;
    int              src;
    int              q;
    if (!in_packet[node]) begin
      compare_value($sformatf("out_flit[%0d].header.dest", node), flit.header.dest, node);
      src = int'(flit.header.src);
      if (src >= nodes) begin
        $display("Node %0d received a header naming source %0d, which does not exist",
                 node, src);
        stop_on_failure();
      end
      cur_src[node] = src;
    end
    src = cur_src[node];
    q   = src * nodes + node;
    if (exp_q[q].size() == 0) begin
      $display("Node %0d received a flit from node %0d that was never sent", node, src);
      stop_on_failure();
    end
    exp = exp_q[q].pop_front();
    compare_value($sformatf("out_flit[%0d]", node), flit.data, exp[flit_w-1:0]);
    compare_value($sformatf("out_last[%0d]", node), last, exp[flit_w]);
    in_packet[node] = !last;
  endtask

  always @(posedge clk) begin
    for (int n = 0; n < nodes; n++) begin
      in_fire[n] = arst_n && in_valid[n] && in_ready[n];
      if (arst_n && out_valid[n] && out_ready[n]) begin
        check_arrival(n, out_flit[n], out_last[n]);
      end
    end
  end

  ////////////////////
  // Drivers

  always @(negedge clk) begin
    for (int n = 0; n < nodes; n++) begin
      if (in_fire[n]) begin
        void'(tx_q[n].pop_front());
      end
      if (tx_q[n].size() > 0) begin
        in_valid[n] = 1'b1;
        in_flit[n]  = tx_q[n][0][flit_w-1:0];
        in_last[n]  = tx_q[n][0][flit_w];
      end else begin
        in_valid[n] = 1'b0;
        in_flit[n]  = '0;
        in_last[n]  = 1'b0;
      end
      if (hold_cnt[n] > 0) begin
        out_ready[n] = 1'b0;
        hold_cnt[n]--;
      end else begin
        out_ready[n] = 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: traffic still in flight after %0d cycles", cycle_limit);
      stop_on_failure();
    end
  end

  ////////////////////
  // Main sequence

  initial begin
    clk         = 1'b0;
    arst_n      = 1'b0;
    in_flit     = '0;
    in_last     = '0;
    in_valid    = '0;
    out_ready   = '1;
    in_fire     = '0;
    rng_state   = 32'he48a;
    cycle_count = 0;
    for (int n = 0; n < nodes; n++) begin
      hold_cnt[n]  = 0;
      in_packet[n] = 1'b0;
      cur_src[n]   = 0;
    end

    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // Idle network after reset
    @(posedge clk);
    #10;
    compare_value("out_valid", out_valid, '0);
    compare_value("in_ready", in_ready, {nodes{1'b1}});

    for (int i = 0; i < num_entries; i++) begin
      if (i > 0 && pkt_table[i].wave != pkt_table[i-1].wave) begin
        wait_idle();
      end
      queue_packet(pkt_table[i]);
    end
    wait_idle();

    // Quiet drain so a duplicated flit would still show up
    repeat (20) @(posedge clk);
    #10;
    if (out_valid !== '0 || in_ready !== '1) begin
      $display("Network not idle after the traffic drained: out_valid 0x%0h, in_ready 0x%0h",
               out_valid, in_ready);
      stop_on_failure();
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* filelist.f */
hdl/noc_topology_pkg.sv
hdl/noc_flit_pkg.sv
hdl/noc_router_input.sv
hdl/noc_router_output.sv
hdl/noc_router.sv
hdl/noc_mesh_2d.sv
verif/noc_mesh_tb.sv

/* Bender.yml */
package:
  name: noc_mesh

sources:
  # Packages first, then the router parts, then the mesh top level
  - hdl/noc_topology_pkg.sv
  - hdl/noc_flit_pkg.sv
  - hdl/noc_router_input.sv
  - hdl/noc_router_output.sv
  - hdl/noc_router.sv
  - hdl/noc_mesh_2d.sv

  - target: simulation
    files:
      - verif/noc_mesh_tb.sv
